// File: src/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Bus widths.
`define ADDR_W          32
`define WORD_W          32
`define BEN_W           4              // One enable per byte.

// Cache geometry. 16 lines of 4 words.
`define LINE_WORDS      4
`define CACHE_LINES     16
`define INDEX_W         4
`define OFFSET_W        4              // Byte offset within a line.
`define TAG_W           24             // ADDR_W - INDEX_W - OFFSET_W.
`endif

// File: src/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

        // ----------------------------------------------------------
        // Basic scalar types.
        // ----------------------------------------------------------
        typedef logic [`WORD_W-1:0]  word_t;        // One data word.
        typedef logic [`BEN_W-1:0]   ben_t;         // Byte enables.
        typedef logic [`ADDR_W-1:0]  addr_t;        // Byte address.
        typedef logic [`INDEX_W-1:0] index_t;       // Line index.
        typedef logic [1:0]          word_sel_t;    // Word within a line.

        // Core side request. Held by the core while stalled.
        typedef struct packed {
                logic  rd;                      // Load.
                logic  wr;                      // Store.
                ben_t  ben;
                addr_t addr;
                word_t wdata;
        } cpu_req_t;

        // RAM command. Held until done.
        typedef struct packed {
                logic  rd_en;
                logic  wr_en;
                ben_t  ben;
                addr_t addr;
                word_t wdata;
        } ram_req_t;

        // Tag store entry.
        typedef struct packed {
                logic              valid;
                logic [`TAG_W-1:0] tag;
        } tag_entry_t;

        // Full cache line, word 0 in the low bits.
        typedef word_t [`LINE_WORDS-1:0] line_t;

        // Controller states.
        typedef enum logic [1:0] {
                LOOKUP,                         // Tag check, hits, write-through.
                FILL,                           // Line fetch from RAM.
                FILL_WRITE                      // Tag commit.
        } cache_state_t;

endpackage

// File: src/indexed_store.sv
`include "cache_settings.svh"

// Direct-mapped storage, one entry per cache line.
// Read is combinational at the current index.
module indexed_store #(
        parameter type entry_t = cache_pkg::tag_entry_t
) (
        input  logic              i_clk,
        input  logic              i_reset,
        input  logic              i_flush,      // Clear all entries.
        input  logic              i_wen,
        input  cache_pkg::index_t i_rindex,
        input  cache_pkg::index_t i_windex,
        input  entry_t            i_wdata,
        output entry_t            o_rdata
);

        // ----------------------------------------------------------
        // Storage.
        // ----------------------------------------------------------
        entry_t entry_q [`CACHE_LINES];         // One entry per line.

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush)
                begin
                        // Zero clears the valid bit too.
                        for (int i = 0; i < `CACHE_LINES; i++)
                                entry_q[i] <= '0;
                end
                else if (i_wen)
                begin
                        entry_q[i_windex] <= i_wdata;   // Single entry update.
                end
        end

        // ----------------------------------------------------------
        // Read port.
        // ----------------------------------------------------------
        // No read register; a hit is served in the request cycle.
        assign o_rdata = entry_q[i_rindex];

endmodule

// File: src/fill_word_counter.sv
`include "cache_settings.svh"

// Word number of a line fill.
module fill_word_counter (
        input  logic                 i_clk,
        input  logic                 i_reset,
        input  logic                 i_clear,       // Held in LOOKUP.
        input  logic                 i_advance,     // One per RAM done.
        output cache_pkg::word_sel_t o_word,
        output logic                 o_last
);
        import cache_pkg::*;

        localparam word_sel_t LAST_WORD = word_sel_t'(`LINE_WORDS - 1);

        word_sel_t count_q;                     // Current fill word.

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                        count_q <= '0;
                else if (i_advance)
                begin
                        // Wrap after the final word.
                        if (count_q == LAST_WORD)
                                count_q <= '0;
                        else
                                count_q <= count_q + 1'b1;
                end
        end

        assign o_word = count_q;
        assign o_last = (count_q == LAST_WORD);  // Final transfer of the line.

endmodule

// File: src/cache_ctrl_fsm.sv
`include "cache_settings.svh"

// Cache controller. Decides hit, miss, fill, write-through and bypass.
module cache_ctrl_fsm (
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  cache_pkg::cpu_req_t     i_req,
        input  logic                    i_cache_en,
        input  logic                    i_cache_inv,
        input  cache_pkg::tag_entry_t   i_tag,
        input  logic                    i_ram_done,
        input  logic                    i_last,
        output cache_pkg::cache_state_t o_state,
        output logic                    o_stall,
        output cache_pkg::ram_req_t     o_ram,
        output logic                    o_tag_wen,
        output logic                    o_line_wen,
        output logic                    o_flush,
        output logic                    o_count_adv,
        output logic                    o_count_clr
);
        import cache_pkg::*;

        cache_state_t      state_q;
        cache_state_t      state_d;
        logic [`TAG_W-1:0] req_tag;             // Tag part of the address.
        logic              access;              // Any request present.
        logic              hit;

        assign req_tag = i_req.addr[`ADDR_W-1 -: `TAG_W];
        assign access  = i_req.rd | i_req.wr;
        assign hit     = i_tag.valid && (i_tag.tag == req_tag);
        assign o_state = state_q;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_q <= LOOKUP;
                else
                        state_q <= state_d;
        end

        // ----------------------------------------------------------
        // Next state and outputs.
        // ----------------------------------------------------------
        always_comb
        begin
                state_d     = state_q;
                o_stall     = 1'b0;
                o_ram       = '0;
                o_tag_wen   = 1'b0;
                o_line_wen  = 1'b0;
                o_count_adv = 1'b0;
                o_count_clr = 1'b0;

                case (state_q)
                LOOKUP:
                begin
                        o_count_clr = 1'b1;             // Fill starts at word 0.
                        if (access && (i_req.wr || !i_cache_en))
                        begin
                                // Write-through, or uncached access.
                                o_ram.rd_en = i_req.rd & ~i_req.wr;
                                o_ram.wr_en = i_req.wr;
                                o_ram.ben   = i_req.ben;
                                o_ram.addr  = i_req.addr;
                                o_ram.wdata = i_req.wdata;
                                o_stall     = !i_ram_done;
                                // Keep a cached copy coherent.
                                o_line_wen  = i_req.wr && hit && i_ram_done;
                        end
                        else if (access && !hit)
                        begin
                                o_stall = 1'b1;         // Read miss.
                                state_d = FILL;
                        end
                        // Read hit falls through with no stall.
                end

                FILL:
                begin
                        // Line base only. Top adds the word offset.
                        o_stall     = 1'b1;
                        o_ram.rd_en = 1'b1;
                        o_ram.ben   = '1;
                        o_ram.addr  = {i_req.addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
                        o_count_adv = i_ram_done;
                        // Last word is live on the RAM bus only now.
                        o_line_wen  = i_ram_done && i_last;
                        if (i_ram_done && i_last)
                                state_d = FILL_WRITE;
                end

                FILL_WRITE:
                begin
                        o_stall   = 1'b1;
                        o_tag_wen = 1'b1;               // Line becomes valid.
                        state_d   = LOOKUP;
                end

                default:
                begin
                        state_d = LOOKUP;
                end
                endcase

                // Invalidate only when idle on the RAM side.
                o_flush = (state_q == LOOKUP) && i_cache_inv && !o_ram.rd_en && !o_ram.wr_en;
        end

endmodule

// File: src/line_assembler.sv
`include "cache_settings.svh"

// Forms the line written into the line store.
module line_assembler (
        input  logic                 i_clk,
        input  logic                 i_reset,
        input  logic                 i_capture,     // RAM word valid.
        input  cache_pkg::word_sel_t i_word,        // Fill word number.
        input  cache_pkg::word_t     i_ram_word,
        input  cache_pkg::cpu_req_t  i_req,
        input  logic                 i_fill,        // Fill in progress.
        input  cache_pkg::line_t     i_old_line,
        output cache_pkg::line_t     o_line
);
        import cache_pkg::*;

        localparam int BUF_WORDS = `LINE_WORDS - 1;     // Last word is never stored.

        word_t     buf_q [BUF_WORDS];
        word_sel_t wr_word;                     // Word hit by a store.
        word_t     merged;

        // ----------------------------------------------------------
        // Fill buffer.
        // ----------------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < BUF_WORDS; i++)
                                buf_q[i] <= '0;
                end
                else if (i_capture && (int'(i_word) < BUF_WORDS))
                begin
                        buf_q[i_word] <= i_ram_word;
                end
        end

        // ----------------------------------------------------------
        // Store merge under byte enables.
        // ----------------------------------------------------------
        assign wr_word = i_req.addr[`OFFSET_W-1:2];

        always_comb
        begin
                merged = i_old_line[wr_word];
                for (int b = 0; b < `BEN_W; b++)
                begin
                        if (i_req.ben[b])
                                merged[8*b +: 8] = i_req.wdata[8*b +: 8];
                end
        end

        always_comb
        begin
                o_line = i_old_line;
                if (i_fill)
                begin
                        for (int w = 0; w < BUF_WORDS; w++)
                                o_line[w] = buf_q[w];
                        o_line[`LINE_WORDS-1] = i_ram_word;     // Live last word.
                end
                else
                begin
                        o_line[wr_word] = merged;
                end
        end

endmodule

// File: src/wt_cache_top.sv
`include "cache_settings.svh"

// Direct-mapped write-through data cache.
module wt_cache_top (
        input  logic                i_clk,
        input  logic                i_reset,
        input  cache_pkg::cpu_req_t i_req,
        input  logic                i_cache_en,
        input  logic                i_cache_inv,
        output cache_pkg::word_t    o_rd_data,
        output logic                o_stall,
        output cache_pkg::ram_req_t o_ram,
        input  cache_pkg::word_t    i_ram_rd_data,
        input  logic                i_ram_done
);
        import cache_pkg::*;

        // ----------------------------------------------------------
        // Nets.
        // ----------------------------------------------------------
        index_t       req_index;
        word_sel_t    req_word;
        tag_entry_t   tag_rd;
        tag_entry_t   tag_wr;
        line_t        line_rd;
        line_t        line_wr;
        cache_state_t state;
        ram_req_t     fsm_ram;                  // Command before word offset.
        word_sel_t    fill_word;
        logic         fill_last;
        logic         tag_wen;
        logic         line_wen;
        logic         flush;
        logic         count_adv;
        logic         count_clr;

        assign req_index = i_req.addr[`OFFSET_W +: `INDEX_W];
        assign req_word  = i_req.addr[`OFFSET_W-1:2];
        assign tag_wr    = '{valid: 1'b1, tag: i_req.addr[`ADDR_W-1 -: `TAG_W]};

        // ----------------------------------------------------------
        // Tag and line stores. Both cleared on invalidate.
        // ----------------------------------------------------------
        indexed_store #(.entry_t(tag_entry_t)) tag_store_i (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_flush  (flush),
                .i_wen    (tag_wen),
                .i_rindex (req_index),
                .i_windex (req_index),
                .i_wdata  (tag_wr),
                .o_rdata  (tag_rd)
        );

        indexed_store #(.entry_t(line_t)) line_store_i (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_flush  (flush),
                .i_wen    (line_wen),
                .i_rindex (req_index),
                .i_windex (req_index),
                .i_wdata  (line_wr),
                .o_rdata  (line_rd)
        );

        fill_word_counter fill_word_counter_i (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_clear   (count_clr),
                .i_advance (count_adv),
                .o_word    (fill_word),
                .o_last    (fill_last)
        );

        // Captures on the same strobe that steps the counter.
        line_assembler line_assembler_i (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_capture  (count_adv),
                .i_word     (fill_word),
                .i_ram_word (i_ram_rd_data),
                .i_req      (i_req),
                .i_fill     (state == FILL),
                .i_old_line (line_rd),
                .o_line     (line_wr)
        );

        cache_ctrl_fsm cache_ctrl_fsm_i (
                .i_clk       (i_clk),
                .i_reset     (i_reset),
                .i_req       (i_req),
                .i_cache_en  (i_cache_en),
                .i_cache_inv (i_cache_inv),
                .i_tag       (tag_rd),
                .i_ram_done  (i_ram_done),
                .i_last      (fill_last),
                .o_state     (state),
                .o_stall     (o_stall),
                .o_ram       (fsm_ram),
                .o_tag_wen   (tag_wen),
                .o_line_wen  (line_wen),
                .o_flush     (flush),
                .o_count_adv (count_adv),
                .o_count_clr (count_clr)
        );

        // ----------------------------------------------------------
        // RAM command and read data.
        // ----------------------------------------------------------
        always_comb
        begin
                o_ram = fsm_ram;
                if (state == FILL)
                        o_ram.addr[`OFFSET_W-1:2] = fill_word;  // Word of the line.
        end

        assign o_rd_data = i_cache_en ? line_rd[req_word] : i_ram_rd_data;

endmodule

// File: test/tb_clock_gen.sv
// Free running testbench clock.
module tb_clock_gen (
        output logic o_clk
);
        localparam int HALF_PERIOD = 2;         // Period of 4.

        initial
        begin
                o_clk = 1'b0;
                forever #HALF_PERIOD o_clk = ~o_clk;
        end

endmodule

// File: test/wt_cache_props.sv
// Protocol checks on the RAM command port.
module wt_cache_props (
        input logic                i_clk,
        input logic                i_reset,
        input cache_pkg::ram_req_t o_ram,
        input logic                i_ram_done
);
        logic active;                           // Any RAM command.
        int   fail_count = 0;                   // Failed assertions so far.

        assign active = o_ram.rd_en || o_ram.wr_en;

        // ----------------------------------------------------------
        // RAM side.
        // ----------------------------------------------------------
        no_dual_cmd: assert property (@(posedge i_clk) disable iff (i_reset)
                !(o_ram.rd_en && o_ram.wr_en))
                else
                begin
                        $error("RAM read and write enables are high together.");
                        fail_count++;
                end

        cmd_held: assert property (@(posedge i_clk) disable iff (i_reset)
                active && !i_ram_done |=> $stable(o_ram))
                else
                begin
                        $error("RAM command changed before done.");
                        fail_count++;
                end

        idle_after_reset: assert property (@(posedge i_clk)
                $fell(i_reset) |-> !active)
                else
                begin
                        $error("RAM command active right after reset.");
                        fail_count++;
                end

endmodule

bind wt_cache_top wt_cache_props wt_cache_props_i (.*);

// File: test/wt_cache_tb.sv
`include "cache_settings.svh"

module wt_cache_tb;
        import cache_pkg::*;

        localparam int TIMEOUT   = 200;         // Cycles per access.
        localparam int RAM_WORDS = 256;         // Model covers 1 KiB.

        logic     i_clk;
        logic     i_reset;
        cpu_req_t i_req;
        logic     i_cache_en;
        logic     i_cache_inv;
        word_t    o_rd_data;
        logic     o_stall;
        ram_req_t o_ram;
        word_t    i_ram_rd_data;
        logic     i_ram_done;
        word_t    ram_q [RAM_WORDS];            // RAM model contents.
        integer   seed;

        tb_clock_gen tb_clock_gen_i (.o_clk(i_clk));

        wt_cache_top wt_cache_top_i (.*);

        // ----------------------------------------------------------
        // Compare tasks.
        // ----------------------------------------------------------
        task automatic stop_run();
                $display("TEST FAILED");
                $fatal(1, "Run stopped at the first error.");
        endtask

        task automatic check_word(input word_t got, input word_t exp, input string what);
                if (got !== exp)
                begin
                        $display("Error at time %0t: %s is %h, expected %h.",
                                 $time, what, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_ram_req(input ram_req_t got, input ram_req_t exp);
                if (got !== exp)
                begin
                        $display("Error at time %0t: RAM command %h, expected %h.",
                                 $time, got, exp);
                        stop_run();
                end
        endtask

        task automatic check_count(input int got, input int exp, input string what);
                if (got != exp)
                begin
                        $display("Error at time %0t: %s is %0d, expected %0d.",
                                 $time, what, got, exp);
                        stop_run();
                end
        endtask

        // Bound protocol assertions.
        always @(negedge i_clk)
        begin
                if (wt_cache_top_i.wt_cache_props_i.fail_count != 0)
                begin
                        $display("A protocol assertion on the RAM port failed.");
                        stop_run();
                end
        end

        // Fill reads walk the line from word 0. Everything else passes through.
        function automatic ram_req_t expected_cmd(input cpu_req_t req, input bit cached,
                                                  input int word_no);
                ram_req_t exp;
                exp = '0;
                if (req.wr || !cached)
                begin
                        exp.rd_en = !req.wr;
                        exp.wr_en = req.wr;
                        exp.ben   = req.ben;
                        exp.addr  = req.addr;
                        exp.wdata = req.wdata;
                end
                else
                begin
                        exp.rd_en = 1'b1;
                        exp.ben   = '1;
                        exp.addr  = {req.addr[`ADDR_W-1:`OFFSET_W], 2'(word_no), 2'b00};
                end
                return exp;
        endfunction

        // ----------------------------------------------------------
        // One core access answered by the RAM model.
        // ----------------------------------------------------------
        task automatic run_access(input cpu_req_t req, output word_t rd_word,
                                  output int reads, output int cycles);
                ram_req_t cmd_q;
                bit       busy;
                bit       finished;
                int       wait_left;
                int       idx;
                busy     = 1'b0;
                finished = 1'b0;
                reads    = 0;
                cycles   = 0;
                rd_word  = '0;
                i_req    = req;
                while (!finished)
                begin
                        @(negedge i_clk);               // Outputs settled.
                        cycles++;
                        if (i_ram_done)
                                busy = 1'b0;            // Retires at the edge.
                        else if (!busy && (o_ram.rd_en || o_ram.wr_en))
                        begin
                                check_ram_req(o_ram, expected_cmd(req, i_cache_en, reads));
                                reads    += o_ram.rd_en;
                                cmd_q     = o_ram;
                                busy      = 1'b1;
                                wait_left = $unsigned($random(seed)) % 3;  // Done in 1 to 3.
                        end
                        if (!o_stall)
                        begin
                                rd_word  = o_rd_data;
                                finished = 1'b1;
                        end
                        else if (cycles >= TIMEOUT)
                        begin
                                $display("Timeout: o_stall stayed high for %0d cycles.", TIMEOUT);
                                stop_run();
                        end
                        @(posedge i_clk);
                        #1;
                        i_ram_done = 1'b0;
                        if (finished)
                                i_req = '0;
                        else if (busy && wait_left == 0)
                        begin
                                idx           = int'(cmd_q.addr[9:2]);
                                i_ram_done    = 1'b1;
                                i_ram_rd_data = ram_q[idx];
                                for (int b = 0; b < `BEN_W; b++)
                                begin
                                        if (cmd_q.wr_en && cmd_q.ben[b])
                                                ram_q[idx][8*b +: 8] = cmd_q.wdata[8*b +: 8];
                                end
                        end
                        else if (busy)
                                wait_left--;
                end
        endtask

        // ----------------------------------------------------------
        // Stimulus.
        // ----------------------------------------------------------
        initial
        begin
                string    line;
                byte      op;
                addr_t    addr;
                ben_t     ben;
                word_t    data;
                word_t    exp_word;
                word_t    got;
                int       exp_reads;
                int       reads;
                int       cycles;
                int       n;
                int       fd;
                cpu_req_t req;
                seed          = 32'h0c9a609a;
                i_reset       = 1'b1;
                i_req         = '0;
                i_cache_en    = 1'b1;
                i_cache_inv   = 1'b0;
                i_ram_done    = 1'b0;
                i_ram_rd_data = '0;
                for (int i = 0; i < RAM_WORDS; i++)
                        ram_q[i] = word_t'(i * 4) ^ 32'h5a5a0000;     // Address XOR pattern.
                repeat (16) @(posedge i_clk);
                #1 i_reset = 1'b0;
                @(posedge i_clk);
                #1;
                fd = $fopen("test/wt_cache_stimulus.txt", "r");
                if (fd == 0)
                begin
                        $display("Could not open the stimulus file.");
                        stop_run();
                end
                while (!$feof(fd))
                begin
                        n = $fgets(line, fd);
                        if (n > 1 && line.getc(0) != "#")
                        begin
                                n = $sscanf(line, "%c %h %h %h %h %d",
                                            op, addr, ben, data, exp_word, exp_reads);
                                if (n != 6)
                                begin
                                        $display("A stimulus line could not be parsed: %s", line);
                                        stop_run();
                                end
                                case (op)
                                "R", "W":
                                begin
                                        req = '{rd: op == "R", wr: op == "W", ben: ben,
                                                addr: addr, wdata: data};
                                        run_access(req, got, reads, cycles);
                                        if (op == "R")
                                                check_word(got, exp_word, "read data");
                                        check_count(reads, exp_reads, "RAM reads");
                                        if (op == "R" && exp_reads == 0 && i_cache_en)
                                                check_count(cycles, 1, "read hit cycles");
                                end
                                "E": i_cache_en = 1'b1;
                                "D": i_cache_en = 1'b0;
                                "I":
                                begin
                                        i_cache_inv = 1'b1;             // One cycle pulse.
                                        @(posedge i_clk);
                                        #1 i_cache_inv = 1'b0;
                                end
                                default:
                                begin
                                        $display("Unknown operation in the stimulus file.");
                                        stop_run();
                                end
                                endcase
                        end
                end
                $fclose(fd);
                if (wt_cache_top_i.wt_cache_props_i.fail_count != 0)
                begin
                        $display("A protocol assertion on the RAM port failed.");
                        stop_run();
                end
                else
                begin
                        $display("TEST PASSED");
                        $finish;
                end
        end

endmodule

// File: project.f
+incdir+src
src/cache_pkg.sv
src/indexed_store.sv
src/fill_word_counter.sv
src/cache_ctrl_fsm.sv
src/line_assembler.sv
src/wt_cache_top.sv
test/tb_clock_gen.sv
test/wt_cache_props.sv
test/wt_cache_tb.sv

// File: Bender.yml
package:
  name: wt_cache

sources:
  - include_dirs:
      - src
    files:
      - src/cache_pkg.sv
      - src/indexed_store.sv
      - src/fill_word_counter.sv
      - src/cache_ctrl_fsm.sv
      - src/line_assembler.sv
      - src/wt_cache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_clock_gen.sv
      - test/wt_cache_props.sv
      - test/wt_cache_tb.sv

// File: test/wt_cache_stimulus.txt
# op addr ben wdata expected_read_word expected_ram_reads (hex, last column decimal)
# op: R read, W write, E enable, D disable, I invalidate
R 00000104 f 00000000 5a5a0104 4
R 0000010c f 00000000 5a5a010c 0
W 00000108 3 1234abcd 00000000 0
R 00000108 f 00000000 5a5aabcd 0
W 00000220 f cafef00d 00000000 0
R 00000220 f 00000000 cafef00d 4
W 00000234 c 11223344 00000000 0
R 00000234 f 00000000 11220234 4
R 00000304 f 00000000 5a5a0304 4
R 00000108 f 00000000 5a5aabcd 4
R 00000220 f 00000000 cafef00d 0
I 00000000 0 00000000 00000000 0
R 00000220 f 00000000 cafef00d 4
D 00000000 0 00000000 00000000 0
R 00000104 f 00000000 5a5a0104 1
W 00000140 1 000000ee 00000000 0
R 00000140 f 00000000 5a5a01ee 1
E 00000000 0 00000000 00000000 0
R 00000140 f 00000000 5a5a01ee 4
R 00000148 f 00000000 5a5a0148 0
